// File: verilog/mipsPkg.sv
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	localparam logic [5:0] opcodeRType = 6'd0;
	localparam logic [5:0] opcodeAddi = 6'd8;
	localparam logic [5:0] opcodeLw = 6'd35;
	localparam logic [5:0] opcodeSw = 6'd43;
	localparam logic [5:0] opcodeBeq = 6'd4;
	localparam logic [5:0] opcodeBne = 6'd5;

	localparam logic [5:0] funcAdd = 6'd32;
	localparam logic [5:0] funcSub = 6'd34;
	localparam logic [5:0] funcAnd = 6'd36;
	localparam logic [5:0] funcSll = 6'd0;
	localparam logic [5:0] funcSrl = 6'd2;
	localparam logic [5:0] funcSra = 6'd3;

	// ALU operand B sources
	localparam logic [1:0] srcBReg = 2'd0;
	localparam logic [1:0] srcBFour = 2'd1;
	localparam logic [1:0] srcBImm = 2'd2;
	localparam logic [1:0] srcBImmShifted = 2'd3; // Branch offset in words

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluSll, aluSrl, aluSra} aluOp;

	typedef enum logic [3:0] {
		fetch, decode, execR, execShift, execImm, memAddr,
		memRead, memWrite, writeAlu, writeMem, branch
	} cpuState;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0] immediate;
	} iFields;

	typedef union packed {
		rFields r;
		iFields i;
	} instrWord;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [dataWidth-1:0] adr;
		logic [dataWidth-1:0] datW;
	} wbRequest;

	typedef struct packed {
		logic ack;
		logic [dataWidth-1:0] datR;
	} wbResponse;

	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic branchOnEqual;
		logic irWrite;
		logic abWrite;
		logic aluOutWrite;
		logic mdrWrite;
		logic regWrite;
		logic regDstRd;
		logic memToReg;
		logic aluSrcA; // 0 PC, 1 register A
		logic [1:0] aluSrcB;
		logic useMemAddr;
		aluOp aluOperation;
	} datapathControl;

endpackage

// File: verilog/registerFile.sv
module registerFile (
	input logic clock,
	input logic [mipsPkg::regAddrWidth-1:0] readAddrA,
	input logic [mipsPkg::regAddrWidth-1:0] readAddrB,
	input logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input logic writeEnable,
	input logic [mipsPkg::dataWidth-1:0] writeValue,
	output logic [mipsPkg::dataWidth-1:0] readValueA,
	output logic [mipsPkg::dataWidth-1:0] readValueB
);

	logic [mipsPkg::dataWidth-1:0] registers [0:31];

	always_ff @(posedge clock) begin
		if (writeEnable && (writeAddr != '0))
			registers[writeAddr] <= writeValue;
	end

	// Register zero always reads as zero
	always_comb begin
		if (readAddrA == '0)
			readValueA = '0;
		else
			readValueA = registers[readAddrA];
	end

	always_comb begin
		if (readAddrB == '0)
			readValueB = '0;
		else
			readValueB = registers[readAddrB];
	end

endmodule

// File: verilog/alu.sv
module alu (
	input logic [mipsPkg::dataWidth-1:0] operandA,
	input logic [mipsPkg::dataWidth-1:0] operandB,
	input logic [4:0] shiftAmount,
	input mipsPkg::aluOp operation,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic zero
);

	always_comb begin
		case (operation)
			mipsPkg::aluAdd: begin
				result = operandA + operandB;
			end
			mipsPkg::aluSub: begin
				result = operandA - operandB;
			end
			mipsPkg::aluAnd: begin
				result = operandA & operandB;
			end
			mipsPkg::aluSll: begin
				result = operandB << shiftAmount; // Shifts act on rt as in MIPS
			end
			mipsPkg::aluSrl: begin
				result = operandB >> shiftAmount;
			end
			mipsPkg::aluSra: begin
				result = $signed(operandB) >>> shiftAmount; // Sign fill
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: verilog/controlFsm.sv
module controlFsm (
	input logic clock,
	input logic reset,
	input mipsPkg::instrWord instruction,
	input logic ack,
	output mipsPkg::datapathControl control,
	output logic cyc,
	output logic stb,
	output logic we
);

	mipsPkg::cpuState state;
	mipsPkg::cpuState nextState;
	logic busActive;
	logic busState;
	logic busDone;

	function automatic mipsPkg::aluOp functOperation(input logic [5:0] funct);
		case (funct)
			mipsPkg::funcSub: return mipsPkg::aluSub;
			mipsPkg::funcAnd: return mipsPkg::aluAnd;
			mipsPkg::funcSll: return mipsPkg::aluSll;
			mipsPkg::funcSrl: return mipsPkg::aluSrl;
			mipsPkg::funcSra: return mipsPkg::aluSra;
			default: return mipsPkg::aluAdd;
		endcase
	endfunction

	assign busState = (state == mipsPkg::fetch) || (state == mipsPkg::memRead) ||
		(state == mipsPkg::memWrite);
	assign busDone = busActive && ack;
	assign cyc = busActive;
	assign stb = busActive;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mipsPkg::fetch;
			busActive <= 1'b0;
			we <= 1'b0;
		end else begin
			state <= nextState;
			if (busDone) begin
				busActive <= 1'b0; // Cycle closes the clock after ack
				we <= 1'b0;
			end else if (busState && !busActive) begin
				busActive <= 1'b1;
				we <= (state == mipsPkg::memWrite);
			end
		end
	end

	always_comb begin
		control = '0;
		control.aluOperation = mipsPkg::aluAdd;
		nextState = state;
		case (state)
			mipsPkg::fetch: begin
				control.aluSrcB = mipsPkg::srcBFour; // PC + 4
				control.irWrite = busDone;
				control.pcWrite = busDone;
				if (busDone)
					nextState = mipsPkg::decode;
			end
			mipsPkg::decode: begin
				control.abWrite = 1'b1;
				control.aluOutWrite = 1'b1; // Branch target
				control.aluSrcB = mipsPkg::srcBImmShifted;
				case (instruction.r.opcode)
					mipsPkg::opcodeRType: begin
						case (instruction.r.funct)
							mipsPkg::funcAdd, mipsPkg::funcSub, mipsPkg::funcAnd:
								nextState = mipsPkg::execR;
							mipsPkg::funcSll, mipsPkg::funcSrl, mipsPkg::funcSra:
								nextState = mipsPkg::execShift;
							default: nextState = mipsPkg::fetch;
						endcase
					end
					mipsPkg::opcodeAddi: nextState = mipsPkg::execImm;
					mipsPkg::opcodeLw, mipsPkg::opcodeSw: nextState = mipsPkg::memAddr;
					mipsPkg::opcodeBeq, mipsPkg::opcodeBne: nextState = mipsPkg::branch;
					default: nextState = mipsPkg::fetch; // Unknown opcode runs as a no-op
				endcase
			end
			mipsPkg::execR, mipsPkg::execShift: begin
				control.aluSrcA = 1'b1;
				control.aluSrcB = mipsPkg::srcBReg;
				control.aluOperation = functOperation(instruction.r.funct);
				control.aluOutWrite = 1'b1;
				nextState = mipsPkg::writeAlu;
			end
			mipsPkg::execImm: begin
				control.aluSrcA = 1'b1;
				control.aluSrcB = mipsPkg::srcBImm;
				control.aluOutWrite = 1'b1;
				nextState = mipsPkg::writeAlu;
			end
			mipsPkg::memAddr: begin
				control.aluSrcA = 1'b1;
				control.aluSrcB = mipsPkg::srcBImm;
				control.aluOutWrite = 1'b1;
				if (instruction.r.opcode == mipsPkg::opcodeLw)
					nextState = mipsPkg::memRead;
				else
					nextState = mipsPkg::memWrite;
			end
			mipsPkg::memRead: begin
				control.useMemAddr = 1'b1;
				control.mdrWrite = busDone;
				if (busDone)
					nextState = mipsPkg::writeMem;
			end
			mipsPkg::memWrite: begin
				control.useMemAddr = 1'b1;
				if (busDone)
					nextState = mipsPkg::fetch;
			end
			mipsPkg::writeAlu: begin
				control.regWrite = 1'b1;
				control.regDstRd = (instruction.r.opcode == mipsPkg::opcodeRType);
				nextState = mipsPkg::fetch;
			end
			mipsPkg::writeMem: begin
				control.regWrite = 1'b1;
				control.memToReg = 1'b1;
				nextState = mipsPkg::fetch;
			end
			mipsPkg::branch: begin
				control.aluSrcA = 1'b1;
				control.aluSrcB = mipsPkg::srcBReg;
				control.aluOperation = mipsPkg::aluSub; // Zero flag gives A == B
				control.pcWriteCond = 1'b1;
				control.branchOnEqual = (instruction.r.opcode == mipsPkg::opcodeBeq);
				nextState = mipsPkg::fetch;
			end
			default: nextState = mipsPkg::fetch;
		endcase
	end

endmodule

// File: verilog/datapath.sv
module datapath (
	input logic clock,
	input logic reset,
	input mipsPkg::datapathControl control,
	input logic [mipsPkg::dataWidth-1:0] readData,
	output mipsPkg::instrWord instruction,
	output logic [mipsPkg::dataWidth-1:0] address,
	output logic [mipsPkg::dataWidth-1:0] writeData
);

	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] regA;
	logic [mipsPkg::dataWidth-1:0] regB;
	logic [mipsPkg::dataWidth-1:0] aluOut;
	logic [mipsPkg::dataWidth-1:0] mdr;
	logic [mipsPkg::dataWidth-1:0] readValueA;
	logic [mipsPkg::dataWidth-1:0] readValueB;
	logic [mipsPkg::dataWidth-1:0] signExtended;
	logic [mipsPkg::dataWidth-1:0] operandA;
	logic [mipsPkg::dataWidth-1:0] operandB;
	logic [mipsPkg::dataWidth-1:0] aluResult;
	logic [mipsPkg::dataWidth-1:0] writeValue;
	logic [mipsPkg::dataWidth-1:0] nextPc;
	logic [mipsPkg::regAddrWidth-1:0] writeAddr;
	logic zero;
	logic takeBranch;

	registerFile registerFile_i (
		.clock(clock),
		.readAddrA(instruction.i.rs),
		.readAddrB(instruction.i.rt),
		.writeAddr(writeAddr),
		.writeEnable(control.regWrite),
		.writeValue(writeValue),
		.readValueA(readValueA),
		.readValueB(readValueB)
	);

	alu alu_i (
		.operandA(operandA),
		.operandB(operandB),
		.shiftAmount(instruction.r.shamt),
		.operation(control.aluOperation),
		.result(aluResult),
		.zero(zero)
	);

	assign signExtended = {{16{instruction.i.immediate[15]}}, instruction.i.immediate};
	assign operandA = control.aluSrcA ? regA : pc;

	always_comb begin
		case (control.aluSrcB)
			mipsPkg::srcBReg: operandB = regB;
			mipsPkg::srcBFour: operandB = 32'd4;
			mipsPkg::srcBImm: operandB = signExtended;
			default: operandB = {signExtended[29:0], 2'b00};
		endcase
	end

	assign writeAddr = control.regDstRd ? instruction.r.rd : instruction.i.rt;
	assign writeValue = control.memToReg ? mdr : aluOut;

	// Branch target sits in aluOut since decode
	assign takeBranch = control.pcWriteCond && (zero == control.branchOnEqual);
	assign nextPc = control.pcWriteCond ? aluOut : aluResult;

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (control.pcWrite || takeBranch)
			pc <= nextPc;
	end

	always_ff @(posedge clock) begin
		if (control.irWrite)
			instruction <= readData;
		if (control.abWrite) begin
			regA <= readValueA;
			regB <= readValueB;
		end
		if (control.aluOutWrite)
			aluOut <= aluResult;
		if (control.mdrWrite)
			mdr <= readData;
	end

	assign address = control.useMemAddr ? aluOut : pc; // Data access or fetch
	assign writeData = regB;

endmodule

// File: verilog/mipsCore.sv
module mipsCore (
	input logic clock,
	input logic reset,
	output mipsPkg::wbRequest bus,
	input mipsPkg::wbResponse busResponse
);

	mipsPkg::datapathControl control;
	mipsPkg::instrWord instruction;

	controlFsm controlFsm_i (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.ack(busResponse.ack),
		.control(control),
		.cyc(bus.cyc),
		.stb(bus.stb),
		.we(bus.we)
	);

	datapath datapath_i (
		.clock(clock),
		.reset(reset),
		.control(control),
		.readData(busResponse.datR),
		.instruction(instruction),
		.address(bus.adr),
		.writeData(bus.datW)
	);

endmodule

// File: testbench/wishboneMemory.sv
module wishboneMemory (
	input logic clock,
	input logic reset,
	input mipsPkg::wbRequest bus,
	output mipsPkg::wbResponse response,
	input logic slowest
);

	timeunit 1ns;
	timeprecision 1ns;

	logic [31:0] mem [0:1023]; // Word addressed, 4 KiB
	logic [31:0] storeAddr [$];
	logic [31:0] storeData [$];
	logic pending;
	logic [1:0] waitLeft;
	logic [31:0] rngState = 32'd74;

	// Wait states of 0 to 3 cycles from an LCG
	function automatic logic [1:0] drawWait();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState[17:16];
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			response.ack <= 1'b0;
			response.datR <= '0;
			pending <= 1'b0;
			waitLeft <= '0;
		end else if (response.ack) begin
			response.ack <= 1'b0; // Single clock ack
		end else if (bus.cyc && bus.stb) begin
			if (!pending) begin
				pending <= 1'b1;
				waitLeft <= slowest ? 2'd3 : drawWait();
			end else if (waitLeft != 0) begin
				waitLeft <= waitLeft - 2'd1;
			end else begin
				pending <= 1'b0;
				response.ack <= 1'b1;
				if (bus.we) begin
					mem[bus.adr[11:2]] = bus.datW;
					storeAddr.push_back(bus.adr);
					storeData.push_back(bus.datW);
				end else begin
					response.datR <= mem[bus.adr[11:2]];
				end
			end
		end
	end

endmodule

// File: testbench/mipsCore_props.sv
module mipsCoreProps (
	input logic clock,
	input logic reset,
	input mipsPkg::wbRequest bus,
	input mipsPkg::wbResponse busResponse
);

	timeunit 1ns;
	timeprecision 1ns;

	stbNeedsCyc: assert property (@(posedge clock) disable iff (reset)
		bus.stb |-> bus.cyc)
		else $error("stb high without cyc");

	// Request held steady until the slave answers
	requestStable: assert property (@(posedge clock) disable iff (reset)
		(bus.stb && !busResponse.ack) |=>
			($stable(bus.adr) && $stable(bus.we) && $stable(bus.datW)))
		else $error("bus request changed before ack");

	idleAfterReset: assert property (@(posedge clock)
		$past(reset) && !reset |-> !bus.cyc)
		else $error("cyc high in first cycle after reset");

endmodule

bind mipsCore mipsCoreProps props_i (
	.clock(clock),
	.reset(reset),
	.bus(bus),
	.busResponse(busResponse)
);

// File: testbench/mipsCoreTb.sv
module mipsCoreTb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int period = 100;
	localparam int resetCycles = 8;
	localparam int numTests = 5;
	localparam int maxInstructions = 16;
	localparam int worstInstrCycles = 20; // LW with three wait states, plus margin
	localparam int testCycles = resetCycles + maxInstructions * worstInstrCycles + 40;
	localparam longint timeoutNs = 2 * numTests * testCycles * period;

	logic clock;
	logic reset;
	logic slowest;
	mipsPkg::wbRequest bus;
	mipsPkg::wbResponse busResponse;

	logic [31:0] code [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] rngState = 32'd74;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	mipsCore mipsCore_i (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.busResponse(busResponse)
	);

	wishboneMemory memory_i (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.response(busResponse),
		.slowest(slowest)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog expired before all tests finished");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState;
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {mipsPkg::opcodeRType, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] haltWord();
		return encodeI(mipsPkg::opcodeBeq, 5'd0, 5'd0, 16'hFFFF); // Branch to itself
	endfunction

	function automatic logic [31:0] fillWord(input int index);
		return index * 32'h9E3779B1 ^ 32'hC3000000;
	endfunction

	function automatic logic [31:0] signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, what,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// Load the program, reset the core, wait for the final store
	task automatic runProgram(input logic slow);
		@(negedge clock);
		reset = 1'b1;
		slowest = slow;
		for (int i = 0; i < 1024; i++)
			memory_i.mem[i] = fillWord(i);
		for (int i = 0; i < code.size(); i++)
			memory_i.mem[i] = code[i];
		memory_i.storeAddr.delete();
		memory_i.storeData.delete();
		repeat (resetCycles) @(negedge clock);
		reset = 1'b0;
		while (!bus.cyc)
			@(negedge clock);
		checkValue("first fetch we", 32'd0, {31'd0, bus.we});
		checkValue("first fetch adr", 32'd0, bus.adr);
		while (memory_i.storeAddr.size() < expAddr.size())
			@(negedge clock);
		repeat (20) @(negedge clock); // Catch stray stores
	endtask

	task automatic compareStores(input string name, input int errorsBefore);
		if (memory_i.storeAddr.size() != expAddr.size()) begin
			$display("CHECK FAILED at %0t ns: %s store count expected %0d got %0d", $time,
				name, expAddr.size(), memory_i.storeAddr.size());
			errorCount++;
		end else begin
			for (int i = 0; i < expAddr.size(); i++) begin
				checkValue($sformatf("%s store %0d address", name, i), expAddr[i],
					memory_i.storeAddr[i]);
				checkValue($sformatf("%s store %0d data", name, i), expData[i],
					memory_i.storeData[i]);
			end
		end
		testsRun++;
		if (errorCount != errorsBefore) begin
			testsFailed++;
			$display("%s: failed with %0d mismatches", name, errorCount - errorsBefore);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	task automatic arithmeticTest(input string name, input logic slow,
		input logic [15:0] immA, input logic [15:0] immB);
		int errorsBefore;
		logic [31:0] a;
		logic [31:0] b;
		errorsBefore = errorCount;
		a = signExtend(immA);
		b = signExtend(immB);
		code = {encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd1, immA),
			encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd2, immB),
			encodeR(5'd1, 5'd2, 5'd3, 5'd0, mipsPkg::funcAdd),
			encodeR(5'd1, 5'd2, 5'd4, 5'd0, mipsPkg::funcSub),
			encodeR(5'd1, 5'd2, 5'd5, 5'd0, mipsPkg::funcAnd),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd3, 16'h0100),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd4, 16'h0104),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd5, 16'h0108),
			haltWord()};
		expAddr.delete();
		expData.delete();
		expectStore(32'h100, a + b);
		expectStore(32'h104, a - b);
		expectStore(32'h108, a & b);
		runProgram(slow);
		compareStores(name, errorsBefore);
	endtask

	task automatic shiftTest();
		int errorsBefore;
		logic [15:0] imm;
		logic [31:0] v;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] s3;
		errorsBefore = errorCount;
		imm = 16'(nextRandom()) | 16'h8000; // Negative value
		v = signExtend(imm);
		s1 = 5'(nextRandom() % 31 + 1);
		s2 = 5'(nextRandom() % 31 + 1);
		s3 = 5'(nextRandom() % 31 + 1);
		code = {encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd1, imm),
			encodeR(5'd0, 5'd1, 5'd2, s1, mipsPkg::funcSll),
			encodeR(5'd0, 5'd1, 5'd3, s2, mipsPkg::funcSrl),
			encodeR(5'd0, 5'd1, 5'd4, s3, mipsPkg::funcSra),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd2, 16'h0180),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd3, 16'h0184),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd4, 16'h0188),
			haltWord()};
		expAddr.delete();
		expData.delete();
		expectStore(32'h180, v << s1);
		expectStore(32'h184, v >> s2);
		// Vacated top bits copy the sign bit
		expectStore(32'h188, (v >> s3) | ({32{v[31]}} & ~(32'hFFFFFFFF >> s3)));
		runProgram(1'b0);
		compareStores("shift", errorsBefore);
	endtask

	task automatic loadStoreTest();
		int errorsBefore;
		logic [15:0] imm;
		errorsBefore = errorCount;
		imm = 16'(nextRandom());
		code = {encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd1, imm),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0200),
			encodeI(mipsPkg::opcodeLw, 5'd0, 5'd2, 16'h0200),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd2, 16'h0204),
			encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd0, 16'h0005),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd0, 16'h0208),
			haltWord()};
		expAddr.delete();
		expData.delete();
		expectStore(32'h200, signExtend(imm));
		expectStore(32'h204, signExtend(imm));
		expectStore(32'h208, 32'd0); // Register zero stays zero
		runProgram(1'b0);
		compareStores("load store", errorsBefore);
	endtask

	// Stores to 0x300 and 0x30C sit only on wrong paths
	task automatic branchTest();
		int errorsBefore;
		errorsBefore = errorCount;
		code = {encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd1, 16'd7),
			encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd2, 16'd7),
			encodeI(mipsPkg::opcodeAddi, 5'd0, 5'd3, 16'd9),
			encodeI(mipsPkg::opcodeBeq, 5'd1, 5'd2, 16'd1),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0300),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0304),
			encodeI(mipsPkg::opcodeBeq, 5'd1, 5'd3, 16'd1),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0308),
			encodeI(mipsPkg::opcodeBne, 5'd1, 5'd3, 16'd1),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h030C),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0310),
			encodeI(mipsPkg::opcodeBne, 5'd1, 5'd2, 16'd1),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0314),
			encodeI(mipsPkg::opcodeSw, 5'd0, 5'd1, 16'h0318),
			haltWord()};
		expAddr.delete();
		expData.delete();
		expectStore(32'h304, 32'd7);
		expectStore(32'h308, 32'd7);
		expectStore(32'h310, 32'd7);
		expectStore(32'h314, 32'd7);
		expectStore(32'h318, 32'd7);
		runProgram(1'b0);
		compareStores("branch", errorsBefore);
	endtask

	initial begin
		logic [15:0] immA;
		logic [15:0] immB;
		reset = 1'b1;
		slowest = 1'b0;
		immA = 16'(nextRandom());
		immB = 16'(nextRandom()) | 16'h8000;
		arithmeticTest("arithmetic", 1'b0, immA, immB);
		shiftTest();
		loadStoreTest();
		branchTest();
		arithmeticTest("arithmetic slow", 1'b1, immA, immB);
		$display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed,
			errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: verilog.f
verilog/mipsPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/controlFsm.sv
verilog/datapath.sv
verilog/mipsCore.sv
testbench/wishboneMemory.sv
testbench/mipsCore_props.sv
testbench/mipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mipsCoreTb
RTL_TOP ?= mipsCore
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
